/* npc_top.f */
logic/npc_isa_pkg.sv
logic/npc_ctrl_pkg.sv
logic/npc_ifs.sv
logic/npc_pc.sv
logic/npc_regfile.sv
logic/npc_ifu.sv
logic/npc_idu.sv
logic/npc_exu.sv
logic/npc_apb_ctrl.sv
logic/npc_top.sv
tests/npc_sva.sv
tests/npc_tb.sv

/* tests/npc_tb.sv */
module npc_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import npc_isa_pkg::*;
  import npc_ctrl_pkg::*;

  localparam int CLK_HALF = 20;
  localparam int CLK_PERIOD = 2 * CLK_HALF;
  localparam int LOOP_N = 30;
  // Instructions retired by the arithmetic, branch and counting programs
  localparam int INSTR_TOTAL = 14 + 12 + (3 + 3 * LOOP_N);
  localparam int APB_OPS = 400;
  localparam int MARGIN_CYCLES = 500;
  localparam int WATCHDOG_CYCLES = 3 * INSTR_TOTAL + 3 * APB_OPS + MARGIN_CYCLES;
  localparam word_t ST_RUN = word_t'(1) << STATUS_RUN_BIT;
  localparam word_t ST_HALT = word_t'(1) << STATUS_HALT_BIT;

  logic      clk;
  logic      rst;
  apb_addr_t paddr;
  logic      psel;
  logic      penable;
  logic      pwrite;
  word_t     pwdata;
  word_t     prdata;
  logic      pready;
  logic      pslverr;
  logic      halted;

  int    errors;
  int    sva_fails;
  int    seed;
  int    path_len;
  inst_t prog[$];
  word_t model[32];
  word_t val;
  word_t r1;
  word_t r2;
  word_t v1;
  word_t v2;

  npc_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .paddr_i   (paddr),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr),
    .halted_o  (halted)
  );

  always #CLK_HALF clk = ~clk;

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run went past %0d cycles", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  task automatic check_eq(input string what, input word_t got, input word_t exp);
    assert (got === exp) else begin
      errors++;
      $display("FAIL %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    assert (got === exp) else begin
      errors++;
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // RV32I encodings
  function automatic inst_t enc_i(input logic [6:0] opc, input int rd, input int rs1,
                                  input int imm);
    logic [11:0] i12;
    i12 = 12'(imm);
    return {i12, 5'(rs1), 3'b000, 5'(rd), opc};
  endfunction

  function automatic inst_t enc_r(input logic sub, input int rd, input int rs1, input int rs2);
    logic [6:0] f7;
    f7 = sub ? 7'b0100000 : 7'b0000000;
    return {f7, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), OP};
  endfunction

  function automatic inst_t enc_u(input logic [6:0] opc, input int rd, input int imm20);
    logic [19:0] u20;
    u20 = 20'(imm20);
    return {u20, 5'(rd), opc};
  endfunction

  function automatic inst_t enc_j(input int rd, input int off);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), JAL};
  endfunction

  function automatic inst_t enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                  input int off);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], BRANCH};
  endfunction

  task automatic new_program();
    prog.delete();
    path_len = 0;
  endtask

  task automatic push_inst(input inst_t inst);
    prog.push_back(inst);
  endtask

  // Executed instructions that change no register
  task automatic put_path(input inst_t inst);
    prog.push_back(inst);
    path_len++;
  endtask

  task automatic put_addi(input int rd, input int rs1, input int imm);
    logic [11:0] i12;
    i12 = 12'(imm);
    put_path(enc_i(OP_IMM, rd, rs1, imm));
    if (rd != 0) begin
      model[rd] = model[rs1] + {{20{i12[11]}}, i12};
    end
  endtask

  task automatic put_op(input logic sub, input int rd, input int rs1, input int rs2);
    put_path(enc_r(sub, rd, rs1, rs2));
    if (rd != 0) begin
      model[rd] = sub ? model[rs1] - model[rs2] : model[rs1] + model[rs2];
    end
  endtask

  task automatic put_upper(input logic [6:0] opc, input int rd, input int imm20);
    word_t pc;
    word_t upper;
    pc = word_t'(prog.size() * 4);
    upper = {20'(imm20), 12'b0};
    put_path(enc_u(opc, rd, imm20));
    if (rd != 0) begin
      model[rd] = (opc == AUIPC) ? pc + upper : upper;
    end
  endtask

  task automatic put_jump(input inst_t inst, input int rd);
    word_t link;
    link = word_t'(prog.size() * 4 + 4);
    put_path(inst);
    if (rd != 0) begin
      model[rd] = link;
    end
  endtask

  task automatic wait_ready();
    int n = 0;
    while (!pready && n < 16) begin
      @(negedge clk);
      n++;
    end
    if (!pready) begin
      errors++;
      $display("APB slave never raised pready at %0t", $time);
    end
  endtask

  task automatic apb_write(input apb_addr_t addr, input word_t data, input logic exp_err);
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b1;
    pwdata  = data;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    wait_ready();
    check_bit($sformatf("pslverr on write to %h", addr), pslverr, exp_err);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output word_t data, input logic exp_err);
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    wait_ready();
    data = prdata;
    check_bit($sformatf("pslverr on read of %h", addr), pslverr, exp_err);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_gpr(input int idx, output word_t data);
    apb_write(REG_GPR_SEL, word_t'(idx), 1'b0);
    apb_read(REG_GPR_DATA, data, 1'b0);
  endtask

  task automatic check_regs();
    word_t d;
    for (int i = 0; i < 32; i++) begin
      read_gpr(i, d);
      check_eq($sformatf("x%0d", i), d, model[i]);
    end
  endtask

  task automatic check_status(input word_t exp);
    word_t st;
    apb_read(REG_STATUS, st, 1'b0);
    check_eq("STATUS", st, exp);
  endtask

  task automatic load_program();
    apb_write(REG_IMEM_ADDR, '0, 1'b0);
    foreach (prog[i]) begin
      apb_write(REG_IMEM_DATA, prog[i], 1'b0);
    end
  endtask

  task automatic start_core();
    apb_write(REG_CTRL, word_t'(1) << CTRL_RUN_BIT, 1'b0);
  endtask

  task automatic wait_halt(input int limit);
    int n = 0;
    while (!halted && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!halted) begin
      errors++;
      $display("Core did not halt within %0d cycles", limit);
    end
  endtask

  task automatic wait_idle();
    word_t st;
    int    n;
    n = 0;
    st = ST_RUN;
    while (st[STATUS_RUN_BIT] && n < 10) begin
      apb_read(REG_STATUS, st, 1'b0);
      n++;
    end
    if (st[STATUS_RUN_BIT]) begin
      errors++;
      $display("Core kept running after the run bit was cleared");
    end
  endtask

  task automatic run_program();
    load_program();
    start_core();
    wait_halt(3 * path_len + 20);
  endtask

  // PC has already moved past the EBREAK, the last word of each program
  task automatic check_halted(input int exp_retired);
    word_t d;
    check_bit("halted_o", halted, 1'b1);
    check_status(ST_HALT);
    apb_read(REG_PC, d, 1'b0);
    check_eq("PC", d, word_t'(prog.size() * 4));
    apb_read(REG_RETIRED, d, 1'b0);
    check_eq("RETIRED", d, word_t'(exp_retired));
    check_regs();
  endtask

  initial begin
    seed    = 52279;
    errors  = 0;
    clk     = 1'b0;
    rst     = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    foreach (model[i]) begin
      model[i] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Reset state
    check_bit("pslverr after reset", pslverr, 1'b0);
    check_eq("prdata after reset", prdata, '0);
    check_bit("halted after reset", halted, 1'b0);
    check_status('0);
    apb_read(REG_PC, val, 1'b0);
    check_eq("PC after reset", val, PC_INIT);
    apb_read(REG_RETIRED, val, 1'b0);
    check_eq("RETIRED after reset", val, '0);
    check_regs();

    // Arithmetic with random immediates
    new_program();
    for (int r = 1; r <= 4; r++) begin
      put_addi(r, 0, $random(seed));
    end
    put_upper(LUI, 5, $random(seed));
    put_upper(AUIPC, 6, $random(seed));
    put_op(1'b0, 7, 1, 2);
    put_op(1'b1, 8, 3, 4);
    put_addi(9, 5, $random(seed));
    put_op(1'b0, 10, 7, 8);
    put_op(1'b1, 11, 6, 9);
    put_addi(0, 1, $random(seed));
    put_op(1'b0, 12, 0, 10);
    put_path(EBREAK_INST);
    run_program();
    check_halted(path_len);

    // Branches and jumps, x15 is written only on wrong paths
    new_program();
    put_addi(13, 0, 5);
    put_addi(14, 0, 5);
    put_path(enc_b(3'b000, 13, 14, 8));
    push_inst(enc_i(OP_IMM, 15, 0, 1));
    put_path(enc_b(3'b001, 13, 14, 8));
    put_addi(16, 0, 2);
    put_path(enc_b(3'b001, 13, 0, 8));
    push_inst(enc_i(OP_IMM, 15, 0, 3));
    put_path(enc_b(3'b000, 13, 0, 8));
    put_jump(enc_j(17, 12), 17);
    push_inst(enc_i(OP_IMM, 15, 0, 4));
    push_inst(EBREAK_INST);
    put_addi(18, 0, 64);
    // Odd target, bit 0 dropped
    put_jump(enc_i(JALR, 19, 18, 1), 19);
    push_inst(enc_i(OP_IMM, 15, 0, 5));
    push_inst(enc_i(OP_IMM, 15, 0, 6));
    put_addi(20, 0, 7);
    put_path(EBREAK_INST);
    run_program();
    check_halted(path_len);

    // APB errors while a counting loop runs
    new_program();
    push_inst(enc_i(OP_IMM, 21, 0, LOOP_N));
    push_inst(enc_i(OP_IMM, 22, 0, 0));
    push_inst(enc_i(OP_IMM, 22, 22, 3));
    push_inst(enc_i(OP_IMM, 21, 21, -1));
    push_inst(enc_b(3'b001, 21, 0, -8));
    push_inst(EBREAK_INST);
    load_program();
    start_core();
    apb_write(REG_IMEM_ADDR, 32'd2, 1'b0);
    apb_write(REG_IMEM_DATA, enc_i(OP_IMM, 22, 22, 100), 1'b1);
    apb_read(REG_IMEM_ADDR, val, 1'b0);
    check_eq("IMEM_ADDR after rejected write", val, 32'd2);
    apb_read(8'h20, val, 1'b1);
    apb_write(8'h24, 32'hFFFF_FFFF, 1'b1);
    apb_write(REG_STATUS, ST_HALT, 1'b1);
    check_status(ST_RUN);
    wait_halt(3 * (3 + 3 * LOOP_N) + 20);
    apb_write(REG_STATUS, '0, 1'b1);
    model[21] = '0;
    model[22] = word_t'(3 * LOOP_N);
    check_halted(3 + 3 * LOOP_N);

    // Stop and restart an endless loop
    new_program();
    push_inst(enc_i(OP_IMM, 25, 25, 1));
    push_inst(enc_j(0, -4));
    load_program();
    start_core();
    check_status(ST_RUN);
    repeat (20) @(negedge clk);
    apb_write(REG_CTRL, '0, 1'b0);
    wait_idle();
    check_status('0);
    check_bit("halted after stop", halted, 1'b0);
    apb_read(REG_RETIRED, r1, 1'b0);
    check_bit("loop retired anything", r1 != '0, 1'b1);
    apb_read(REG_PC, val, 1'b0);
    // Odd count stops after the ADDI, even after the jump back
    check_eq("PC after stop", val, r1[0] ? 32'd4 : 32'd0);
    read_gpr(25, v1);
    check_eq("x25 after stop", v1, model[25] + (r1 + 1) / 2);
    start_core();
    repeat (20) @(negedge clk);
    apb_write(REG_CTRL, '0, 1'b0);
    wait_idle();
    apb_read(REG_RETIRED, r2, 1'b0);
    apb_read(REG_PC, val, 1'b0);
    check_eq("PC after second stop", val, r2[0] ? 32'd4 : 32'd0);
    read_gpr(25, v2);
    check_eq("x25 after restart", v2, v1 + (r2 + 1) / 2);

    sva_fails = dut_i.u_sva.fail_count;
    $display("Check errors: %0d, assertion failures: %0d", errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* tests/npc_sva.sv */
module npc_sva (
  input logic clk,
  input logic rst,
  input logic psel_i,
  input logic penable_i,
  input logic pready_i,
  input logic pslverr_i,
  input logic halted_i,
  input logic start_i,
  input logic retire_i,
  input logic rf_we_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  pready_on_select: assert property (@(posedge clk) disable iff (rst) psel_i |-> pready_i)
    else begin
      fail_count++;
      $error("pready low during a selected APB transfer");
    end

  // Error response only in the access phase
  pslverr_in_access: assert property (@(posedge clk) disable iff (rst)
    !(psel_i && penable_i) |-> !pslverr_i)
    else begin
      fail_count++;
      $error("pslverr high outside the APB access phase");
    end

  rf_write_on_retire: assert property (@(posedge clk) disable iff (rst) rf_we_i |-> retire_i)
    else begin
      fail_count++;
      $error("register file written without a retire");
    end

  halt_falls_on_start: assert property (@(posedge clk) disable iff (rst)
    $fell(halted_i) |-> start_i)
    else begin
      fail_count++;
      $error("halted dropped without a start pulse");
    end

endmodule

bind npc_top npc_sva u_sva (
  .clk       (clk),
  .rst       (rst),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pready_i  (pready_o),
  .pslverr_i (pslverr_o),
  .halted_i  (halted_o),
  .start_i   (ctrl_if.start),
  .retire_i  (retire),
  .rf_we_i   (rf_we)
);

/* logic/npc_top.sv */
module npc_top (
  input  logic                    clk,
  input  logic                    rst,
  input  npc_ctrl_pkg::apb_addr_t paddr_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  npc_isa_pkg::word_t      pwdata_i,
  output npc_isa_pkg::word_t      prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  output logic                    halted_o
);
  import npc_isa_pkg::*;

  word_t     pc;
  word_t     npc;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     rf_wdata;
  inst_t     inst;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rf_waddr;
  logic      rf_we;
  logic      ifu_valid;
  logic      idu_ready;
  logic      retire;
  logic      halt;

  npc_dec_if  dec_if ();
  npc_ctrl_if ctrl_if ();

  assign ctrl_if.retire = retire;
  assign ctrl_if.halt   = halt;
  assign ctrl_if.pc     = pc;

  npc_apb_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .halted_o  (halted_o),
    .ctrl      (ctrl_if.ctrl)
  );

  npc_pc u_pc (
    .clk      (clk),
    .rst      (rst),
    .start_i  (ctrl_if.start),
    .retire_i (retire),
    .npc_i    (npc),
    .pc_o     (pc)
  );

  npc_regfile #(
    .NUM_REGS (32)
  ) u_rf (
    .clk        (clk),
    .rst        (rst),
    .we_i       (rf_we),
    .waddr_i    (rf_waddr),
    .wdata_i    (rf_wdata),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .dbg_sel_i  (ctrl_if.gpr_sel),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .dbg_data_o (ctrl_if.gpr_data)
  );

  npc_ifu u_ifu (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl_if.core),
    .retire_i (retire),
    .pc_i     (pc),
    .ready_i  (idu_ready),
    .valid_o  (ifu_valid),
    .inst_o   (inst)
  );

  npc_idu u_idu (
    .clk        (clk),
    .rst        (rst),
    .valid_i    (ifu_valid),
    .inst_i     (inst),
    .pc_i       (pc),
    .ready_o    (idu_ready),
    .rs1_o      (rs1),
    .rs2_o      (rs2),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .dec        (dec_if.idu)
  );

  npc_exu u_exu (
    .clk        (clk),
    .rst        (rst),
    .dec        (dec_if.exu),
    .rf_we_o    (rf_we),
    .rf_waddr_o (rf_waddr),
    .rf_wdata_o (rf_wdata),
    .npc_o      (npc),
    .retire_o   (retire),
    .halt_o     (halt)
  );

endmodule

/* logic/npc_apb_ctrl.sv */
module npc_apb_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  npc_ctrl_pkg::apb_addr_t paddr_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  npc_isa_pkg::word_t      pwdata_i,
  output npc_isa_pkg::word_t      prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  output logic                    halted_o,
  npc_ctrl_if.ctrl                ctrl
);
  import npc_isa_pkg::*;
  import npc_ctrl_pkg::*;

  core_state_e state;
  logic        run_q;
  logic        start_q;
  word_t       retired_q;
  imem_addr_t  imem_addr_q;
  reg_addr_t   gpr_sel_q;
  logic        setup;
  logic        wr;
  logic        mapped;
  logic        read_only;
  logic        bad;
  word_t       rdata;

  assign setup = psel_i & ~penable_i;
  // Erroring access writes nothing
  assign wr    = psel_i & penable_i & pwrite_i & ~pslverr_o;

  always_comb begin
    mapped    = 1'b1;
    read_only = 1'b0;
    rdata     = '0;
    case (paddr_i)
      REG_CTRL: rdata[CTRL_RUN_BIT] = run_q;
      REG_STATUS: begin
        read_only              = 1'b1;
        rdata[STATUS_RUN_BIT]  = (state == RUN);
        rdata[STATUS_HALT_BIT] = (state == HALT);
      end
      REG_PC: begin
        read_only = 1'b1;
        rdata     = ctrl.pc;
      end
      REG_RETIRED: begin
        read_only = 1'b1;
        rdata     = retired_q;
      end
      REG_IMEM_ADDR: rdata = word_t'(imem_addr_q);
      REG_IMEM_DATA: rdata = '0;
      REG_GPR_SEL:   rdata = word_t'(gpr_sel_q);
      REG_GPR_DATA: begin
        read_only = 1'b1;
        rdata     = ctrl.gpr_data;
      end
      default: mapped = 1'b0;
    endcase
  end

  assign bad = !mapped || (pwrite_i && read_only) ||
               (pwrite_i && paddr_i == REG_IMEM_DATA && state == RUN);

  // Response is decided in setup and presented in the access phase
  always_ff @(posedge clk) begin
    if (rst) begin
      prdata_o  <= '0;
      pslverr_o <= 1'b0;
    end else begin
      pslverr_o <= setup & bad;
      if (setup && !pwrite_i) begin
        prdata_o <= rdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      run_q       <= 1'b0;
      start_q     <= 1'b0;
      retired_q   <= '0;
      imem_addr_q <= '0;
      gpr_sel_q   <= '0;
    end else begin
      start_q <= 1'b0;
      if (ctrl.retire) begin
        retired_q <= retired_q + 32'd1;
      end
      // Stop requests take effect at an instruction boundary
      if (state == RUN && ctrl.retire) begin
        if (ctrl.halt) begin
          state <= HALT;
          run_q <= 1'b0;
        end else if (!run_q) begin
          state <= IDLE;
        end
      end
      if (wr) begin
        case (paddr_i)
          REG_CTRL: begin
            run_q <= pwdata_i[CTRL_RUN_BIT];
            if (pwdata_i[CTRL_RUN_BIT] && state != RUN) begin
              start_q   <= 1'b1;
              state     <= RUN;
              retired_q <= '0;
            end
          end
          REG_IMEM_ADDR: imem_addr_q <= imem_addr_t'(pwdata_i);
          REG_IMEM_DATA: imem_addr_q <= imem_addr_q + 1'b1;
          REG_GPR_SEL:   gpr_sel_q <= reg_addr_t'(pwdata_i);
          default: ;
        endcase
      end
    end
  end

  assign ctrl.start      = start_q;
  assign ctrl.run        = run_q & ~ctrl.halt;
  assign ctrl.imem_we    = wr & (paddr_i == REG_IMEM_DATA);
  assign ctrl.imem_waddr = imem_addr_q;
  assign ctrl.imem_wdata = pwdata_i;
  assign ctrl.gpr_sel    = gpr_sel_q;

  assign pready_o = 1'b1;
  assign halted_o = (state == HALT);

endmodule

/* logic/npc_exu.sv */
module npc_exu (
  input  logic                   clk,
  input  logic                   rst,
  npc_dec_if.exu                 dec,
  output logic                   rf_we_o,
  output npc_isa_pkg::reg_addr_t rf_waddr_o,
  output npc_isa_pkg::word_t     rf_wdata_o,
  output npc_isa_pkg::word_t     npc_o,
  output logic                   retire_o,
  output logic                   halt_o
);
  import npc_isa_pkg::*;

  logic  fire;
  logic  taken;
  logic  halt_q;
  word_t alu_res;
  word_t jalr_sum;

  assign dec.ready = 1'b1;
  assign fire      = dec.valid & dec.ready;

  always_comb begin
    case (dec.alu_op)
      SUB:     alu_res = dec.op1 - dec.op2;
      PASS_B:  alu_res = dec.op2;
      ADD_PC:  alu_res = dec.pc + dec.op2;
      default: alu_res = dec.op1 + dec.op2;
    endcase
  end

  assign taken    = (dec.is_beq && dec.op1 == dec.op2) || (dec.is_bne && dec.op1 != dec.op2);
  assign jalr_sum = dec.op1 + dec.imm;

  always_comb begin
    if (dec.is_jal || taken) begin
      npc_o = dec.pc + dec.imm;
    end else if (dec.is_jalr) begin
      npc_o = {jalr_sum[31:1], 1'b0};
    end else begin
      npc_o = dec.pc + 32'd4;
    end
  end

  assign rf_we_o    = fire & dec.rwen;
  assign rf_waddr_o = dec.rd;
  assign rf_wdata_o = alu_res;
  assign retire_o   = fire;

  // Halt stays up while the core sits on EBREAK, until the next retire
  always_ff @(posedge clk) begin
    if (rst) begin
      halt_q <= 1'b0;
    end else if (fire) begin
      halt_q <= dec.is_ebreak;
    end
  end

  assign halt_o = fire ? dec.is_ebreak : halt_q;

endmodule

/* logic/npc_idu.sv */
module npc_idu (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   valid_i,
  input  npc_isa_pkg::inst_t     inst_i,
  input  npc_isa_pkg::word_t     pc_i,
  output logic                   ready_o,
  output npc_isa_pkg::reg_addr_t rs1_o,
  output npc_isa_pkg::reg_addr_t rs2_o,
  input  npc_isa_pkg::word_t     rs1_data_i,
  input  npc_isa_pkg::word_t     rs2_data_i,
  npc_dec_if.idu                 dec
);
  import npc_isa_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_j;
  word_t      imm_b;
  alu_op_e    alu_op;
  word_t      op2;
  word_t      imm;
  logic       rwen;
  logic       is_jal;
  logic       is_jalr;
  logic       is_beq;
  logic       is_bne;
  logic       is_ebreak;
  logic       take;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  assign rs1_o  = inst_i[19:15];
  assign rs2_o  = inst_i[24:20];

  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
  assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

  assign ready_o = ~dec.valid | dec.ready;
  assign take    = valid_i & ready_o;

  // Anything outside the subset falls through as a no-op
  always_comb begin
    alu_op    = ADD;
    op2       = imm_i;
    imm       = imm_i;
    rwen      = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_beq    = 1'b0;
    is_bne    = 1'b0;
    is_ebreak = 1'b0;
    case (opcode)
      OP_IMM: rwen = (funct3 == 3'b000);
      OP: begin
        op2  = rs2_data_i;
        rwen = (funct3 == 3'b000) && (funct7 == 7'b0000000 || funct7 == 7'b0100000);
        if (funct7 == 7'b0100000) begin
          alu_op = SUB;
        end
      end
      LUI: begin
        alu_op = PASS_B;
        op2    = imm_u;
        rwen   = 1'b1;
      end
      AUIPC: begin
        alu_op = ADD_PC;
        op2    = imm_u;
        rwen   = 1'b1;
      end
      // Link is PC plus four
      JAL: begin
        alu_op = ADD_PC;
        op2    = 32'd4;
        imm    = imm_j;
        rwen   = 1'b1;
        is_jal = 1'b1;
      end
      JALR: begin
        alu_op  = ADD_PC;
        op2     = 32'd4;
        rwen    = (funct3 == 3'b000);
        is_jalr = (funct3 == 3'b000);
      end
      BRANCH: begin
        op2    = rs2_data_i;
        imm    = imm_b;
        is_beq = (funct3 == 3'b000);
        is_bne = (funct3 == 3'b001);
      end
      SYSTEM: is_ebreak = (inst_i == EBREAK_INST);
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec.valid <= 1'b0;
    end else if (take) begin
      dec.valid <= 1'b1;
    end else if (dec.ready) begin
      dec.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      dec.alu_op    <= alu_op;
      dec.op1       <= rs1_data_i;
      dec.op2       <= op2;
      dec.imm       <= imm;
      dec.pc        <= pc_i;
      dec.rd        <= inst_i[11:7];
      dec.rwen      <= rwen;
      dec.is_jal    <= is_jal;
      dec.is_jalr   <= is_jalr;
      dec.is_beq    <= is_beq;
      dec.is_bne    <= is_bne;
      dec.is_ebreak <= is_ebreak;
    end
  end

endmodule

/* logic/npc_ifu.sv */
module npc_ifu (
  input  logic               clk,
  input  logic               rst,
  npc_ctrl_if.core           ctrl,
  input  logic               retire_i,
  input  npc_isa_pkg::word_t pc_i,
  input  logic               ready_i,
  output logic               valid_o,
  output npc_isa_pkg::inst_t inst_o
);
  import npc_isa_pkg::*;
  import npc_ctrl_pkg::*;

  inst_t      mem [IMEM_DEPTH];
  logic       fetch_q;
  imem_addr_t fetch_idx;

  assign fetch_idx = pc_i[$bits(imem_addr_t)+1:2];

  // Host load port
  always_ff @(posedge clk) begin
    if (ctrl.imem_we) begin
      mem[ctrl.imem_waddr] <= ctrl.imem_wdata;
    end
  end

  // Issue trails start or retire by one cycle so the PC has settled
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_q <= 1'b0;
      valid_o <= 1'b0;
    end else begin
      fetch_q <= ctrl.start | (retire_i & ctrl.run);
      if (fetch_q) begin
        valid_o <= 1'b1;
      end else if (valid_o && ready_i) begin
        valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_q) begin
      inst_o <= mem[fetch_idx];
    end
  end

endmodule

/* logic/npc_regfile.sv */
module npc_regfile #(
  parameter int NUM_REGS = 32
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   we_i,
  input  npc_isa_pkg::reg_addr_t waddr_i,
  input  npc_isa_pkg::word_t     wdata_i,
  input  npc_isa_pkg::reg_addr_t rs1_i,
  input  npc_isa_pkg::reg_addr_t rs2_i,
  input  npc_isa_pkg::reg_addr_t dbg_sel_i,
  output npc_isa_pkg::word_t     rs1_data_o,
  output npc_isa_pkg::word_t     rs2_data_o,
  output npc_isa_pkg::word_t     dbg_data_o
);
  import npc_isa_pkg::*;

  word_t regs [NUM_REGS];

  // x0 and indexes beyond the file (RV32E) read as zero
  assign rs1_data_o = (rs1_i != '0 && int'(rs1_i) < NUM_REGS) ? regs[rs1_i] : '0;
  assign rs2_data_o = (rs2_i != '0 && int'(rs2_i) < NUM_REGS) ? regs[rs2_i] : '0;
  assign dbg_data_o = (dbg_sel_i != '0 && int'(dbg_sel_i) < NUM_REGS) ? regs[dbg_sel_i] : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0 && int'(waddr_i) < NUM_REGS) begin
      regs[waddr_i] <= wdata_i;
    end
  end

endmodule

/* logic/npc_pc.sv */
module npc_pc (
  input  logic               clk,
  input  logic               rst,
  input  logic               start_i,
  input  logic               retire_i,
  input  npc_isa_pkg::word_t npc_i,
  output npc_isa_pkg::word_t pc_o
);
  import npc_isa_pkg::*;

  // Restart always begins at the reset vector
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_o <= PC_INIT;
    end else if (start_i) begin
      pc_o <= PC_INIT;
    end else if (retire_i) begin
      pc_o <= npc_i;
    end
  end

endmodule

/* logic/npc_ifs.sv */
interface npc_dec_if;
  import npc_isa_pkg::*;

  logic      valid;
  logic      ready;
  alu_op_e   alu_op;
  word_t     op1;
  word_t     op2;
  word_t     imm;
  word_t     pc;
  reg_addr_t rd;
  logic      rwen;
  logic      is_jal;
  logic      is_jalr;
  logic      is_beq;
  logic      is_bne;
  logic      is_ebreak;

  modport idu (
    output valid, alu_op, op1, op2, imm, pc, rd, rwen,
    output is_jal, is_jalr, is_beq, is_bne, is_ebreak,
    input  ready
  );

  modport exu (
    input  valid, alu_op, op1, op2, imm, pc, rd, rwen,
    input  is_jal, is_jalr, is_beq, is_bne, is_ebreak,
    output ready
  );
endinterface

interface npc_ctrl_if;
  import npc_isa_pkg::*;
  import npc_ctrl_pkg::*;

  logic       start;
  logic       run;
  logic       imem_we;
  imem_addr_t imem_waddr;
  word_t      imem_wdata;
  reg_addr_t  gpr_sel;
  logic       retire;
  logic       halt;
  word_t      pc;
  word_t      gpr_data;

  modport ctrl (
    output start, run, imem_we, imem_waddr, imem_wdata, gpr_sel,
    input  retire, halt, pc, gpr_data
  );

  modport core (
    input  start, run, imem_we, imem_waddr, imem_wdata, gpr_sel,
    output retire, halt, pc, gpr_data
  );
endinterface

/* logic/npc_ctrl_pkg.sv */
package npc_ctrl_pkg;

  typedef logic [7:0] apb_addr_t;

  localparam apb_addr_t REG_CTRL      = 8'h00;
  localparam apb_addr_t REG_STATUS    = 8'h04;
  localparam apb_addr_t REG_PC        = 8'h08;
  localparam apb_addr_t REG_RETIRED   = 8'h0C;
  localparam apb_addr_t REG_IMEM_ADDR = 8'h10;
  localparam apb_addr_t REG_IMEM_DATA = 8'h14;
  localparam apb_addr_t REG_GPR_SEL   = 8'h18;
  localparam apb_addr_t REG_GPR_DATA  = 8'h1C;

  localparam int CTRL_RUN_BIT    = 0;
  localparam int STATUS_RUN_BIT  = 0;
  localparam int STATUS_HALT_BIT = 1;

  localparam int IMEM_DEPTH = 256;
  typedef logic [$clog2(IMEM_DEPTH)-1:0] imem_addr_t;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    HALT
  } core_state_e;

endpackage

/* logic/npc_isa_pkg.sv */
package npc_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;

  // ADD_PC adds to the instruction PC, for AUIPC and the link address
  typedef enum logic [1:0] {
    ADD,
    SUB,
    PASS_B,
    ADD_PC
  } alu_op_e;

  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP     = 7'b0110011;
  localparam logic [6:0] LUI    = 7'b0110111;
  localparam logic [6:0] AUIPC  = 7'b0010111;
  localparam logic [6:0] JAL    = 7'b1101111;
  localparam logic [6:0] JALR   = 7'b1100111;
  localparam logic [6:0] BRANCH = 7'b1100011;
  localparam logic [6:0] SYSTEM = 7'b1110011;

  localparam inst_t EBREAK_INST = 32'h0010_0073;

  localparam word_t PC_INIT = 32'h0000_0000;

endpackage
